/* verilog/starkPkg.sv */
// =========================================================================
// Shared definitions for the dispatch stage
// Instruction and opcode field types
// Opcode constants for the FPU class and the integer class
// Credit count type and the dispatch controller state encoding
// =========================================================================

package starkPkg;

	// =========================================================================
	// Field types
	// =========================================================================

	// One instruction word as sent by the fetch unit
	typedef logic [31:0] instructionT;

	// Opcode field, taken from the low seven bits of the instruction
	typedef logic [6:0] opcodeT;

	// Free credit count of one issue port, enough for up to 15 credits
	typedef logic [3:0] creditT;

	// =========================================================================
	// Opcode constants
	// =========================================================================

	// FPU class, these are steered to the FPU issue port
	localparam opcodeT opFlt = 7'h10;
	localparam opcodeT opAdd = 7'h11;
	localparam opcodeT opCmp = 7'h12;
	localparam opcodeT opAnd = 7'h13;
	localparam opcodeT opOr = 7'h14;
	localparam opcodeT opXor = 7'h15;
	localparam opcodeT opMov = 7'h16;
	localparam opcodeT opNop = 7'h17;

	// Integer class, these are steered to the integer issue port
	localparam opcodeT opLoad = 7'h20;
	localparam opcodeT opStore = 7'h21;
	localparam opcodeT opBranch = 7'h22;
	localparam opcodeT opShift = 7'h23;
	localparam opcodeT opMul = 7'h24;

	// Any other opcode value is illegal and gets dropped at dispatch

	// =========================================================================
	// Controller states
	// =========================================================================

	// Idle means the buffer is empty
	// Issue means the head went out on the last decision
	// Stall means the head is held because its port has no credit
	typedef enum logic [1:0]
	{
		stIdle,
		stIssue,
		stStall
	} dispatchStateT;

endpackage

/* verilog/starkDecodeUnit.sv */
// =========================================================================
// Opcode classifier for the head of the instruction buffer
// Flags an FPU-class opcode and flags any legal opcode
// Purely combinational, one table lookup per class
// =========================================================================

`timescale 1ns/1ns

module starkDecodeUnit (
	input starkPkg::instructionT instr,
	output logic isFpu,
	output logic isLegal
);
	import starkPkg::*;

	// Opcode field of the instruction being looked at
	opcodeT opcode;

	// FPU class table, every other code is not an FPU op
	function automatic logic fnIsFpu(input opcodeT op);
	begin
		case (op)
		opFlt:	fnIsFpu = 1'b1;
		opAdd:	fnIsFpu = 1'b1;
		opCmp:	fnIsFpu = 1'b1;
		opAnd:	fnIsFpu = 1'b1;
		opOr:	fnIsFpu = 1'b1;
		opXor:	fnIsFpu = 1'b1;
		opMov:	fnIsFpu = 1'b1;
		opNop:	fnIsFpu = 1'b1;
		default:	fnIsFpu = 1'b0;
		endcase
	end
	endfunction

	// Integer class table
	function automatic logic fnIsInt(input opcodeT op);
	begin
		case (op)
		opLoad:	fnIsInt = 1'b1;
		opStore:	fnIsInt = 1'b1;
		opBranch:	fnIsInt = 1'b1;
		opShift:	fnIsInt = 1'b1;
		opMul:	fnIsInt = 1'b1;
		default:	fnIsInt = 1'b0;
		endcase
	end
	endfunction

	// The opcode sits in the low bits of the word
	assign opcode = instr[6:0];

	assign isFpu = fnIsFpu(opcode);

	// Legal is anything found in either table
	// The two tables do not overlap, so isFpu alone picks the port
	assign isLegal = fnIsFpu(opcode) || fnIsInt(opcode);

endmodule

/* verilog/starkCreditCounter.sv */
// =========================================================================
// Credit counter for one issue port
// Loads the starting credits at reset, counts down on take
// and up on a credit returned by the consumer
// =========================================================================

`timescale 1ns/1ns

module starkCreditCounter #(
	parameter int Credits = 3
) (
	input logic clk,
	input logic rst,
	input logic take,
	input logic giveBack,
	output logic hasCredit
);
	import starkPkg::*;

	// Free credits held for this port
	creditT count;

	// A take and a return in the same cycle cancel out
	always_ff @(posedge clk)
	begin
		if (rst)
			count <= creditT'(Credits);
		else if (take && !giveBack)
			count <= count - creditT'(1);
		else if (giveBack && !take)
			count <= count + creditT'(1);
	end

	// The port may issue whenever one credit is left
	assign hasCredit = (count != '0);

	// =========================================================================
	// Checks
	// =========================================================================

	// The controller must never take from an empty counter
	// since that would mean it issued to a port without credit
	takeAtZero: assert property (@(posedge clk) disable iff (rst)
		take |-> (count != '0));

	// The consumer must not return more than it was given
	overCredit: assert property (@(posedge clk) disable iff (rst)
		count <= creditT'(Credits));

endmodule

/* verilog/starkInstrBuffer.sv */
// =========================================================================
// Instruction buffer between the fetch unit and dispatch
// Circular FIFO with read pointer, write pointer and occupancy count
// Returns one upstream credit, registered, for every entry popped
// =========================================================================

`timescale 1ns/1ns

module starkInstrBuffer #(
	parameter int FifoDepth = 4
) (
	input logic clk,
	input logic rst,
	input logic inValid,
	input starkPkg::instructionT inInstr,
	input logic pop,
	output logic headValid,
	output starkPkg::instructionT headInstr,
	output logic inCredit
);
	import starkPkg::*;

	// Pointer width stays at least one bit for a single entry buffer
	localparam int PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
	localparam int CntW = $clog2(FifoDepth + 1);

	// Entry storage, payload only
	instructionT mem [FifoDepth];

	logic [PtrW-1:0] rdPtr;
	logic [PtrW-1:0] wrPtr;
	logic [CntW-1:0] count;
	logic full;
	logic wrEn;

	assign full = (count == CntW'(FifoDepth));

	// Upstream only sends while it holds a credit, so full is a guard
	assign wrEn = inValid && !full;

	always_ff @(posedge clk)
	begin
		if (wrEn)
			mem[wrPtr] <= inInstr;
	end

	// Pointers wrap at the depth so any depth works, not only powers of two
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
			inCredit <= 1'b0;
		end
		else
		begin
			if (wrEn)
				wrPtr <= (wrPtr == PtrW'(FifoDepth - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == PtrW'(FifoDepth - 1)) ? '0 : rdPtr + 1'b1;
			if (wrEn && !pop)
				count <= count + 1'b1;
			else if (pop && !wrEn)
				count <= count - 1'b1;
			// Each drained entry frees a slot, illegal ones included
			inCredit <= pop;
		end
	end

	// Head is visible in the cycle after it is written
	assign headValid = (count != '0);
	assign headInstr = mem[rdPtr];

	// =========================================================================
	// Checks
	// =========================================================================

	// A write while full means upstream sent without a credit
	noOverrun: assert property (@(posedge clk) disable iff (rst)
		inValid |-> !full);

	// The controller only pops a valid head
	noUnderrun: assert property (@(posedge clk) disable iff (rst)
		pop |-> headValid);

endmodule

/* verilog/starkDispatchCtrl.sv */
// =========================================================================
// Dispatch controller
// Pops the buffer head when its port has credit and takes that credit
// Registers the issue outputs and the illegal pulse
// Tracks idle, issue and stall in a small FSM
// =========================================================================

`timescale 1ns/1ns

module starkDispatchCtrl (
	input logic clk,
	input logic rst,
	input logic headValid,
	input logic isFpu,
	input logic isLegal,
	input starkPkg::instructionT headInstr,
	input logic fpuHasCredit,
	input logic intHasCredit,
	output logic pop,
	output logic fpuTake,
	output logic intTake,
	output logic fpuValid,
	output logic intValid,
	output logic illegal,
	output starkPkg::instructionT fpuInstr,
	output starkPkg::instructionT intInstr
);
	import starkPkg::*;

	dispatchStateT state;
	dispatchStateT nextState;
	logic portReady;

	// Illegal heads need no credit, they are simply dropped
	assign portReady = !isLegal || (isFpu ? fpuHasCredit : intHasCredit);

	// Pop and take happen together so one instruction can leave per cycle
	// A head whose port is out of credit blocks the other port as well
	assign pop = headValid && portReady;
	assign fpuTake = pop && isLegal && isFpu;
	assign intTake = pop && isLegal && !isFpu;

	// =========================================================================
	// State machine
	// =========================================================================

	always_comb
	begin
		nextState = state;
		case (state)
		stIdle, stIssue:
			begin
				if (!headValid)
					nextState = stIdle;
				else if (portReady)
					nextState = stIssue;
				else
					nextState = stStall;
			end
		stStall:
			begin
				// The head is held until its port gets a credit back
				if (!headValid)
					nextState = stIdle;
				else if (portReady)
					nextState = stIssue;
			end
		default:
			nextState = stIdle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= stIdle;
			fpuValid <= 1'b0;
			intValid <= 1'b0;
			illegal <= 1'b0;
		end
		else
		begin
			state <= nextState;
			fpuValid <= fpuTake;
			intValid <= intTake;
			// Dropped heads are flagged one cycle after the pop
			illegal <= pop && !isLegal;
		end
	end

	// Issue payload follows the valid registers
	always_ff @(posedge clk)
	begin
		if (fpuTake)
			fpuInstr <= headInstr;
		if (intTake)
			intInstr <= headInstr;
	end

	// Only one instruction leaves per cycle, so the ports never fire together
	oneIssue: assert property (@(posedge clk) disable iff (rst)
		!(fpuValid && intValid));

	// While stalled the buffer must keep presenting the same head
	// since nothing was popped on the edge that entered the stall
	holdOnStall: assert property (@(posedge clk) disable iff (rst)
		(state == stStall) |-> (headValid && $stable(headInstr)));

endmodule

/* verilog/starkDispatch.sv */
// =========================================================================
// Dispatch stage top level
// Instruction buffer, opcode decoder, dispatch controller
// and one credit counter for each issue port
// =========================================================================

`timescale 1ns/1ns

module starkDispatch #(
	parameter int FifoDepth = 4,
	parameter int FpuCredits = 3,
	parameter int IntCredits = 3
) (
	input logic clk,
	input logic rst,
	input logic inValid,
	input starkPkg::instructionT inInstr,
	input logic fpuCreditReturn,
	input logic intCreditReturn,
	output logic inCredit,
	output logic fpuValid,
	output starkPkg::instructionT fpuInstr,
	output logic intValid,
	output starkPkg::instructionT intInstr,
	output logic illegal
);
	import starkPkg::*;

	// Buffer head as seen by the decoder and the controller
	logic headValid;
	instructionT headInstr;

	// Classification of the head
	logic isFpu;
	logic isLegal;

	// Controller handshakes
	logic pop;
	logic fpuTake;
	logic intTake;
	logic fpuHasCredit;
	logic intHasCredit;

	// The buffer depth is also the number of credits upstream starts with
	starkInstrBuffer #(
		.FifoDepth(FifoDepth)
	) buffer_i (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.inInstr(inInstr),
		.pop(pop),
		.headValid(headValid),
		.headInstr(headInstr),
		.inCredit(inCredit)
	);

	starkDecodeUnit decode_i (
		.instr(headInstr),
		.isFpu(isFpu),
		.isLegal(isLegal)
	);

	starkDispatchCtrl ctrl_i (
		.clk(clk),
		.rst(rst),
		.headValid(headValid),
		.isFpu(isFpu),
		.isLegal(isLegal),
		.headInstr(headInstr),
		.fpuHasCredit(fpuHasCredit),
		.intHasCredit(intHasCredit),
		.pop(pop),
		.fpuTake(fpuTake),
		.intTake(intTake),
		.fpuValid(fpuValid),
		.intValid(intValid),
		.illegal(illegal),
		.fpuInstr(fpuInstr),
		.intInstr(intInstr)
	);

	// One counter per port, credits come back from each consumer
	starkCreditCounter #(
		.Credits(FpuCredits)
	) fpuCredit_i (
		.clk(clk),
		.rst(rst),
		.take(fpuTake),
		.giveBack(fpuCreditReturn),
		.hasCredit(fpuHasCredit)
	);

	starkCreditCounter #(
		.Credits(IntCredits)
	) intCredit_i (
		.clk(clk),
		.rst(rst),
		.take(intTake),
		.giveBack(intCreditReturn),
		.hasCredit(intHasCredit)
	);

endmodule

/* tb/starkDispatchVectors.svh */
// =========================================================================
// Stimulus table for the dispatch stage testbench
// Port codes for the expected destination of each entry
// One table entry per instruction, applied in order
// =========================================================================

`ifndef STARK_DISPATCH_VECTORS_SVH
`define STARK_DISPATCH_VECTORS_SVH

// Columns: expected port code (upper two bits), instruction word (low 32 bits)
// The opcode is the low seven bits of the word, so bit 7 is don't care
localparam logic [1:0] PortFpu = 2'd0;
localparam logic [1:0] PortInt = 2'd1;
localparam logic [1:0] PortDrop = 2'd2;

localparam int NumVectors = 24;

function automatic logic [33:0] tableEntry(input int idx);
begin
	case (idx)
	0:	tableEntry = {PortFpu, 32'hA5C3_0010};
	1:	tableEntry = {PortInt, 32'h0000_1120};
	2:	tableEntry = {PortFpu, 32'h1234_5611};
	3:	tableEntry = {PortInt, 32'hDEAD_BE21};
	4:	tableEntry = {PortDrop, 32'h0000_0000};
	5:	tableEntry = {PortFpu, 32'hFFFF_FF92};
	6:	tableEntry = {PortInt, 32'h0BAD_F022};
	7:	tableEntry = {PortFpu, 32'h7777_7713};
	8:	tableEntry = {PortInt, 32'hC0DE_0023};
	9:	tableEntry = {PortDrop, 32'h0000_007F};
	10:	tableEntry = {PortFpu, 32'h5555_5514};
	11:	tableEntry = {PortInt, 32'h8888_88A4};
	12:	tableEntry = {PortFpu, 32'h0102_0315};
	13:	tableEntry = {PortDrop, 32'h0000_0018};
	14:	tableEntry = {PortFpu, 32'hFACE_0016};
	15:	tableEntry = {PortFpu, 32'hBEEF_0097};
	16:	tableEntry = {PortInt, 32'h3141_5920};
	17:	tableEntry = {PortDrop, 32'h2718_2825};
	18:	tableEntry = {PortFpu, 32'h0F0F_0F10};
	19:	tableEntry = {PortInt, 32'h600D_0021};
	20:	tableEntry = {PortDrop, 32'h0000_000F};
	21:	tableEntry = {PortFpu, 32'hABCD_EF11};
	22:	tableEntry = {PortInt, 32'h9999_99A2};
	23:	tableEntry = {PortFpu, 32'h4444_4413};
	default:	tableEntry = {PortDrop, 32'h0000_0000};
	endcase
end
endfunction

`endif

/* tb/starkDispatchTb.sv */
// =========================================================================
// Testbench for the dispatch stage
// Clock and reset, upstream credit model, consumer models with random
// credit return delays, per port scoreboard and the latency check
// =========================================================================

`timescale 1ns/1ns

module starkDispatchTb;
	import starkPkg::*;

	// Mirrors the default parameters of the DUT
	localparam int FifoDepth = 4;
	localparam int FpuCredits = 3;
	localparam int IntCredits = 3;
	localparam int WaitLimit = 2000;

	logic clk;
	logic rst;
	logic inValid;
	instructionT inInstr;
	logic fpuCreditReturn;
	logic intCreditReturn;
	logic inCredit;
	logic fpuValid;
	instructionT fpuInstr;
	logic intValid;
	instructionT intInstr;
	logic illegal;

	logic [31:0] lfsr;
	// Credits held by the upstream source
	int srcCredits;
	// Credits the consumers still hold, and issues not yet returned
	int fpuOwed;
	int intOwed;
	int fpuOutstanding;
	int intOutstanding;
	int fpuDelay;
	int intDelay;
	int dropPending;
	int dropSent;
	int illegalSeen;
	int valueErrors;
	int otherErrors;
	logic timedOut;
	instructionT expFpu[$];
	instructionT expInt[$];

	`include "starkDispatchVectors.svh"

	starkDispatch starkDispatch_i (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.inInstr(inInstr),
		.fpuCreditReturn(fpuCreditReturn),
		.intCreditReturn(intCreditReturn),
		.inCredit(inCredit),
		.fpuValid(fpuValid),
		.fpuInstr(fpuInstr),
		.intValid(intValid),
		.intInstr(intInstr),
		.illegal(illegal)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Galois LFSR, taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
	begin
		if (s[0])
			lfsrNext = (s >> 1) ^ 32'h8020_0003;
		else
			lfsrNext = s >> 1;
	end
	endfunction

	// One LFSR step per bit drawn
	task automatic drawBits(input int n, output int value);
		value = 0;
		for (int k = 0; k < n; k++)
		begin
			lfsr = lfsrNext(lfsr);
			value = (value << 1) | int'(lfsr[0]);
		end
	endtask

	// =========================================================================
	// Scoreboard and consumer models
	// =========================================================================

	task automatic observeOutputs();
		instructionT expected;
		if (fpuValid)
		begin
			assert (expFpu.size() > 0) else
			begin
				otherErrors++;
				$display("FPU port issued %h while no FPU instruction was expected", fpuInstr);
			end
			if (expFpu.size() > 0)
			begin
				expected = expFpu.pop_front();
				assert (fpuInstr === expected) else
				begin
					valueErrors++;
					$display("** Error: fpuInstr = %h, expected %h", fpuInstr, expected);
				end
			end
			fpuOutstanding++;
			fpuOwed++;
			// The port may only run ahead of the returns by its starting credits
			assert (fpuOutstanding <= FpuCredits) else
			begin
				otherErrors++;
				$display("FPU port issued with no credit left, %0d outstanding", fpuOutstanding);
			end
		end
		if (intValid)
		begin
			assert (expInt.size() > 0) else
			begin
				otherErrors++;
				$display("INT port issued %h while no INT instruction was expected", intInstr);
			end
			if (expInt.size() > 0)
			begin
				expected = expInt.pop_front();
				assert (intInstr === expected) else
				begin
					valueErrors++;
					$display("** Error: intInstr = %h, expected %h", intInstr, expected);
				end
			end
			intOutstanding++;
			intOwed++;
			assert (intOutstanding <= IntCredits) else
			begin
				otherErrors++;
				$display("INT port issued with no credit left, %0d outstanding", intOutstanding);
			end
		end
		if (illegal)
		begin
			illegalSeen++;
			assert (dropPending > 0) else
			begin
				otherErrors++;
				$display("Illegal pulse seen with no illegal instruction in flight");
			end
			if (dropPending > 0)
				dropPending--;
		end
	endtask

	// Each consumer hands back one credit at a time after a random delay
	task automatic returnCredits();
		fpuCreditReturn = 1'b0;
		intCreditReturn = 1'b0;
		if (fpuDelay > 0)
			fpuDelay--;
		else if (fpuOwed > 0)
		begin
			fpuCreditReturn = 1'b1;
			fpuOwed--;
			fpuOutstanding--;
			// Long FPU delays force the head to stall
			drawBits(4, fpuDelay);
		end
		if (intDelay > 0)
			intDelay--;
		else if (intOwed > 0)
		begin
			intCreditReturn = 1'b1;
			intOwed--;
			intOutstanding--;
			drawBits(3, intDelay);
		end
	endtask

	// Advances to the next falling edge and runs all the models there
	task automatic stepCycle();
		@(negedge clk);
		inValid = 1'b0;
		observeOutputs();
		if (inCredit)
			srcCredits++;
		assert (srcCredits <= FifoDepth) else
		begin
			otherErrors++;
			$display("Upstream got back more credits than it spent, now %0d", srcCredits);
		end
		returnCredits();
	endtask

	task automatic sendInstr(input instructionT word, input logic [1:0] port);
		inValid = 1'b1;
		inInstr = word;
		srcCredits--;
		case (port)
		PortFpu:	expFpu.push_back(word);
		PortInt:	expInt.push_back(word);
		default:
			begin
				dropPending++;
				dropSent++;
			end
		endcase
	endtask

	function automatic logic drained();
	begin
		drained = (expFpu.size() == 0) && (expInt.size() == 0) && (dropPending == 0)
			&& (srcCredits == FifoDepth) && (fpuOwed == 0) && (intOwed == 0);
	end
	endfunction

	// =========================================================================
	// Test sequence
	// =========================================================================

	initial
	begin
		int gap;
		int waited;
		logic [33:0] entry;
		rst = 1'b1;
		inValid = 1'b0;
		inInstr = '0;
		fpuCreditReturn = 1'b0;
		intCreditReturn = 1'b0;
		lfsr = 32'h4080f201;
		srcCredits = FifoDepth;
		fpuOwed = 0;
		intOwed = 0;
		fpuOutstanding = 0;
		intOutstanding = 0;
		fpuDelay = 0;
		intDelay = 0;
		dropPending = 0;
		dropSent = 0;
		illegalSeen = 0;
		valueErrors = 0;
		otherErrors = 0;
		timedOut = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Single FPU instruction into an empty, fully credited path
		stepCycle();
		sendInstr(32'h0BEE_F410, PortFpu);
		stepCycle();
		assert (!fpuValid) else
		begin
			otherErrors++;
			$display("fpuValid rose one cycle after the input edge instead of two");
		end
		stepCycle();
		assert (fpuValid) else
		begin
			otherErrors++;
			$display("fpuValid was not high two cycles after the input edge");
		end

		// Table entries with random gaps, sent only while a credit is held
		for (int i = 0; i < NumVectors && !timedOut; i++)
		begin
			entry = tableEntry(i);
			drawBits(2, gap);
			repeat (gap) stepCycle();
			waited = 0;
			while (srcCredits == 0 && waited < WaitLimit)
			begin
				stepCycle();
				waited++;
			end
			assert (srcCredits > 0) else
			begin
				timedOut = 1'b1;
				otherErrors++;
				$display("Timed out waiting for an upstream credit at entry %0d", i);
			end
			if (srcCredits > 0)
			begin
				sendInstr(entry[31:0], entry[33:32]);
				stepCycle();
			end
		end

		// Everything must come out and all credits must come home
		if (!timedOut)
		begin
			waited = 0;
			while (!drained() && waited < WaitLimit)
			begin
				stepCycle();
				waited++;
			end
			assert (drained()) else
			begin
				otherErrors++;
				$display("Timed out draining, %0d FPU and %0d INT instructions missing",
					expFpu.size(), expInt.size());
			end
		end

		assert (illegalSeen == dropSent) else
		begin
			valueErrors++;
			$display("** Error: illegal pulses = %h, expected %h", illegalSeen, dropSent);
		end
		assert (srcCredits == FifoDepth) else
		begin
			valueErrors++;
			$display("** Error: srcCredits = %h, expected %h", srcCredits, FifoDepth);
		end

		$display("Errors: %0d value, %0d other", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* sources.f */
+incdir+tb
verilog/starkPkg.sv
verilog/starkDecodeUnit.sv
verilog/starkCreditCounter.sv
verilog/starkInstrBuffer.sv
verilog/starkDispatchCtrl.sv
verilog/starkDispatch.sv
tb/starkDispatchTb.sv

/* Bender.yml */
package:
  name: stark_dispatch

sources:
  # RTL in compile order, package first
  - files:
      - verilog/starkPkg.sv
      - verilog/starkDecodeUnit.sv
      - verilog/starkCreditCounter.sv
      - verilog/starkInstrBuffer.sv
      - verilog/starkDispatchCtrl.sv
      - verilog/starkDispatch.sv

  # Testbench with the stimulus table header
  - target: test
    include_dirs:
      - tb
    files:
      - tb/starkDispatchTb.sv
